/* common/frontend_pkg.sv */
package frontend_pkg;

  // instruction queue sizing
  localparam int QUEUE_DEPTH = 16;
  localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CW    = QUEUE_AW + 1;
  // one response in flight plus one new pair
  localparam int QUEUE_ROOM  = 4;

  // source and destination register selects
  localparam logic [1:0] REG_R0_NONE = 2'd0;
  localparam logic [1:0] REG_R0_RK   = 2'd1;
  localparam logic [1:0] REG_R0_RD   = 2'd2;
  localparam logic       REG_R1_NONE = 1'b0;
  localparam logic       REG_R1_RJ   = 1'b1;
  localparam logic [1:0] REG_W_NONE  = 2'd0;
  localparam logic [1:0] REG_W_RD    = 2'd1;
  localparam logic [1:0] REG_W_RJD   = 2'd2;
  localparam logic [1:0] REG_W_BL1   = 2'd3;

  // opcode values of the supported subset, sliced from the top of the word
  localparam logic [16:0] OP17_ADD_W   = 17'h00020;
  localparam logic [16:0] OP17_SUB_W   = 17'h00022;
  localparam logic [16:0] OP17_AND     = 17'h00029;
  localparam logic [16:0] OP17_OR      = 17'h0002a;
  localparam logic [16:0] OP17_IDLE    = 17'h00c91;
  localparam logic [9:0]  OP10_ADDI_W  = 10'h00a;
  localparam logic [9:0]  OP10_LD_W    = 10'h0a2;
  localparam logic [9:0]  OP10_ST_W    = 10'h0a6;
  localparam logic [6:0]  OP7_LU12I_W  = 7'h0a;
  localparam logic [5:0]  OP6_JIRL     = 6'h13;
  localparam logic [5:0]  OP6_BL       = 6'h15;
  localparam logic [5:0]  OP6_BEQ      = 6'h16;
  localparam logic [5:0]  OP6_BNE      = 6'h17;

  // register view of a word
  typedef struct packed {
    logic [16:0] opcode;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } inst_reg_t;

  // immediate view of the same word
  typedef struct packed {
    logic [5:0]  major;
    logic [25:0] imm26;
  } inst_imm_t;

  typedef union packed {
    inst_reg_t r;
    inst_imm_t i;
  } inst_word_u;

  typedef enum logic [3:0] {
    CLS_ALU3R,
    CLS_ALUI12,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_BL,
    CLS_JIRL,
    CLS_LU12I,
    CLS_IDLE,
    CLS_INVALID
  } inst_class_e;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
    inst_class_e cls;
    logic [25:0] imm26;
    logic [4:0]  src0;
    logic [4:0]  src1;
    logic [4:0]  dst;
    logic        dec_valid;
  } decoded_inst_t;

endpackage

/* common/fetch_if.sv */
`timescale 1ns/100ps

interface fetch_if;
  // pair returned by the instruction memory
  logic [1:0]  wr_mask;
  logic [1:0]  wr_num;
  logic [31:0] pc_base;
  logic [31:0] word0;
  logic [31:0] word1;
  // queue has space for another request
  logic        room;

  modport src (
    output wr_mask, wr_num, pc_base, word0, word1,
    input  room
  );

  modport snk (
    input  wr_mask, wr_num, pc_base, word0, word1,
    output room
  );
endinterface

/* fetch/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        redirect_i,
  input  logic [31:0] redirect_target_i,
  input  logic [63:0] imem_data_i,
  input  logic        wait_i,
  input  logic        int_i,
  output logic        imem_req_o,
  output logic [31:0] imem_addr_o,
  output logic        idle_o,
  fetch_if.src        fif
);

  logic [31:0] pc_q;
  logic        run_q;
  logic        idle_q;
  logic        resp_vld_q;
  logic [1:0]  resp_mask_q;
  logic [31:0] resp_pc_q;

  // fetch starts the cycle after reset is released
  assign imem_req_o  = run_q && fif.room && !redirect_i && !idle_q;
  assign imem_addr_o = {pc_q[31:3], 3'b000};
  assign idle_o      = idle_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (redirect_i) begin
      pc_q <= redirect_target_i;
    end else if (imem_req_o) begin
      pc_q <= imem_addr_o + 32'd8;
    end
  end

  // a redirect blocks the request, so nothing is left pending after it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_vld_q <= 1'b0;
    end else begin
      resp_vld_q <= imem_req_o;
    end
  end

  always_ff @(posedge clk) begin
    if (imem_req_o) begin
      // odd-word pc keeps only the upper half of the pair
      resp_mask_q <= pc_q[2] ? 2'b10 : 2'b11;
      resp_pc_q   <= imem_addr_o;
    end
  end

  // idle latch where an interrupt wins over a new wait
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_q <= 1'b0;
    end else if (wait_i && !int_i) begin
      idle_q <= 1'b1;
    end else if (int_i) begin
      idle_q <= 1'b0;
    end
  end

  assign fif.wr_mask = resp_vld_q ? resp_mask_q : 2'b00;
  assign fif.wr_num  = !resp_vld_q ? 2'd0 : (resp_mask_q == 2'b11) ? 2'd2 : 2'd1;
  assign fif.pc_base = resp_pc_q;
  assign fif.word0   = imem_data_i[31:0];
  assign fif.word1   = imem_data_i[63:32];

  // redirect targets are whole words
  a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_i |-> (redirect_target_i[1:0] == 2'b00));

endmodule

/* logic/inst_queue.sv */
`timescale 1ns/100ps

module inst_queue (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic [1:0]  rd_num_i,
  output logic [1:0]  rd_valid_o,
  output logic [31:0] rd_word0_o,
  output logic [31:0] rd_word1_o,
  output logic [31:0] rd_pc0_o,
  output logic [31:0] rd_pc1_o,
  fetch_if.snk        fif
);

  import frontend_pkg::*;

  logic [31:0]         pc_mem   [QUEUE_DEPTH];
  logic [31:0]         word_mem [QUEUE_DEPTH];
  logic [QUEUE_AW-1:0] head_q;
  logic [QUEUE_AW-1:0] tail_q;
  logic [QUEUE_AW-1:0] head_p1;
  logic [QUEUE_AW-1:0] tail_p1;
  logic [QUEUE_CW-1:0] count_q;
  logic [31:0]         in_pc0;
  logic [31:0]         in_pc1;
  logic [31:0]         in_word0;
  logic [31:0]         in_word1;

  assign head_p1 = head_q + 1'b1;
  assign tail_p1 = tail_q + 1'b1;

  // compact the pair so a lone upper word goes into the first free entry
  assign in_pc0   = fif.wr_mask[0] ? fif.pc_base : fif.pc_base + 32'd4;
  assign in_word0 = fif.wr_mask[0] ? fif.word0 : fif.word1;
  assign in_pc1   = fif.pc_base + 32'd4;
  assign in_word1 = fif.word1;

  always_ff @(posedge clk) begin
    if (fif.wr_num != 2'd0) begin
      pc_mem[tail_q]   <= in_pc0;
      word_mem[tail_q] <= in_word0;
    end
    if (fif.wr_num == 2'd2) begin
      pc_mem[tail_p1]   <= in_pc1;
      word_mem[tail_p1] <= in_word1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + rd_num_i;
      tail_q  <= tail_q + fif.wr_num;
      count_q <= count_q + fif.wr_num - rd_num_i;
    end
  end

  // two oldest entries, read combinationally
  assign rd_valid_o = {count_q >= QUEUE_CW'(2), count_q != '0};
  assign rd_word0_o = word_mem[head_q];
  assign rd_pc0_o   = pc_mem[head_q];
  assign rd_word1_o = word_mem[head_p1];
  assign rd_pc1_o   = pc_mem[head_p1];

  assign fif.room = count_q <= QUEUE_CW'(QUEUE_DEPTH - QUEUE_ROOM);

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
    (count_q + fif.wr_num) <= QUEUE_CW'(QUEUE_DEPTH));

  // the issue buffer never takes more than the queue offers
  a_no_overpop: assert property (@(posedge clk) disable iff (!rst_n)
    {{(QUEUE_CW-2){1'b0}}, rd_num_i} <= count_q);

endmodule

/* decode/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
  input  logic [31:0]                word_i,
  input  logic [31:0]                pc_i,
  output frontend_pkg::decoded_inst_t dec_o
);

  import frontend_pkg::*;

  inst_word_u  iw;
  inst_class_e cls;
  logic [1:0]  r0_sel;
  logic        r1_sel;
  logic [1:0]  w_sel;

  assign iw = word_i;

  // classify and pick register selects
  always_comb begin
    cls    = CLS_INVALID;
    r0_sel = REG_R0_NONE;
    r1_sel = REG_R1_NONE;
    w_sel  = REG_W_NONE;
    if (iw.r.opcode == OP17_ADD_W || iw.r.opcode == OP17_SUB_W ||
        iw.r.opcode == OP17_AND || iw.r.opcode == OP17_OR) begin
      cls    = CLS_ALU3R;
      r0_sel = REG_R0_RK;
      r1_sel = REG_R1_RJ;
      w_sel  = REG_W_RD;
    end else if (iw.r.opcode == OP17_IDLE) begin
      cls = CLS_IDLE;
    end else if (iw.r.opcode[16:7] == OP10_ADDI_W) begin
      cls    = CLS_ALUI12;
      r1_sel = REG_R1_RJ;
      w_sel  = REG_W_RD;
    end else if (iw.r.opcode[16:7] == OP10_LD_W) begin
      cls    = CLS_LOAD;
      r1_sel = REG_R1_RJ;
      w_sel  = REG_W_RD;
    end else if (iw.r.opcode[16:7] == OP10_ST_W) begin
      // rd carries the store data
      cls    = CLS_STORE;
      r0_sel = REG_R0_RD;
      r1_sel = REG_R1_RJ;
    end else if (iw.r.opcode[16:10] == OP7_LU12I_W) begin
      cls   = CLS_LU12I;
      w_sel = REG_W_RD;
    end else if (iw.i.major == OP6_BEQ || iw.i.major == OP6_BNE) begin
      cls    = CLS_BRANCH;
      r0_sel = REG_R0_RD;
      r1_sel = REG_R1_RJ;
    end else if (iw.i.major == OP6_BL) begin
      cls   = CLS_BL;
      w_sel = REG_W_BL1;
    end else if (iw.i.major == OP6_JIRL) begin
      cls    = CLS_JIRL;
      r1_sel = REG_R1_RJ;
      w_sel  = REG_W_RJD;
    end
  end

  // register numbers from the selects
  always_comb begin
    dec_o           = '0;
    dec_o.pc        = pc_i;
    dec_o.word      = word_i;
    dec_o.cls       = cls;
    dec_o.dec_valid = (cls != CLS_INVALID);
    dec_o.imm26     = (cls == CLS_INVALID) ? 26'd0 : iw.i.imm26;
    case (r0_sel)
      REG_R0_RK: dec_o.src0 = iw.r.rk;
      REG_R0_RD: dec_o.src0 = iw.r.rd;
      default:   dec_o.src0 = 5'd0;
    endcase
    dec_o.src1 = (r1_sel == REG_R1_RJ) ? iw.r.rj : 5'd0;
    case (w_sel)
      REG_W_RD:  dec_o.dst = iw.r.rd;
      REG_W_RJD: dec_o.dst = iw.r.rd | iw.r.rj;
      // bl links through r1
      REG_W_BL1: dec_o.dst = 5'd1;
      default:   dec_o.dst = 5'd0;
    endcase
  end

endmodule

/* decode/issue_buffer.sv */
`timescale 1ns/100ps

module issue_buffer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush_i,
  input  logic [1:0]                  q_valid_i,
  input  logic [31:0]                 q_word0_i,
  input  logic [31:0]                 q_word1_i,
  input  logic [31:0]                 q_pc0_i,
  input  logic [31:0]                 q_pc1_i,
  input  logic [1:0]                  issue_i,
  output logic [1:0]                  rd_num_o,
  output logic [1:0]                  inst_valid_o,
  output frontend_pkg::decoded_inst_t inst0_o,
  output frontend_pkg::decoded_inst_t inst1_o
);

  import frontend_pkg::*;

  decoded_inst_t [1:0] dec;
  decoded_inst_t [1:0] slot_q;
  decoded_inst_t [1:0] slot_d;
  logic [1:0]          vld_q;
  logic [1:0]          vld_d;

  inst_decoder u_dec0 (
    .word_i (q_word0_i),
    .pc_i   (q_pc0_i),
    .dec_o  (dec[0])
  );

  inst_decoder u_dec1 (
    .word_i (q_word1_i),
    .pc_i   (q_pc1_i),
    .dec_o  (dec[1])
  );

  // shift the survivor down and refill from the queue heads
  always_comb begin
    rd_num_o = 2'd0;
    vld_d    = vld_q;
    slot_d   = slot_q;
    unique casez ({vld_q, q_valid_i, issue_i})
      // empty, take whatever the queue offers
      6'b00????: begin
        vld_d    = q_valid_i;
        slot_d   = dec;
        rd_num_o = q_valid_i[1] ? 2'd2 : {1'b0, q_valid_i[0]};
      end
      // one held
      6'b01?0?0: vld_d = 2'b01;
      6'b01?0?1: vld_d = 2'b00;
      6'b01?1?0: begin
        vld_d     = 2'b11;
        slot_d[1] = dec[0];
        rd_num_o  = 2'd1;
      end
      6'b01?1?1: begin
        vld_d     = 2'b01;
        slot_d[0] = dec[0];
        rd_num_o  = 2'd1;
      end
      // two held
      6'b1???00: vld_d = 2'b11;
      6'b1?0001: begin
        vld_d     = 2'b01;
        slot_d[0] = slot_q[1];
      end
      6'b1?001?: vld_d = 2'b00;
      6'b1?0101, 6'b1?1?01: begin
        vld_d     = 2'b11;
        slot_d[0] = slot_q[1];
        slot_d[1] = dec[0];
        rd_num_o  = 2'd1;
      end
      6'b1?011?: begin
        vld_d     = 2'b01;
        slot_d[0] = dec[0];
        rd_num_o  = 2'd1;
      end
      6'b1?1?1?: begin
        vld_d    = 2'b11;
        slot_d   = dec;
        rd_num_o = 2'd2;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      vld_q <= 2'b00;
    end else begin
      vld_q <= vld_d;
    end
  end

  always_ff @(posedge clk) begin
    slot_q <= slot_d;
  end

  assign inst_valid_o = vld_q;
  assign inst0_o      = slot_q[0];
  assign inst1_o      = slot_q[1];

  // backend acks only held slots, and slot 1 only with slot 0
  a_issue_rule: assert property (@(posedge clk) disable iff (!rst_n)
    (issue_i != 2'b10) && ((issue_i & ~vld_q) == 2'b00));

  // an unacknowledged head stays put until issued or flushed
  a_head_held: assert property (@(posedge clk) disable iff (!rst_n)
    (vld_q[0] && !issue_i[0] && !flush_i) |=> vld_q[0] && $stable(slot_q[0].pc));

endmodule

/* logic/core_frontend.sv */
`timescale 1ns/100ps

module core_frontend (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        redirect_i,
  input  logic [31:0]                 redirect_target_i,
  output logic                        imem_req_o,
  output logic [31:0]                 imem_addr_o,
  input  logic [63:0]                 imem_data_i,
  input  logic                        wait_i,
  input  logic                        int_i,
  output logic                        idle_o,
  output logic [1:0]                  inst_valid_o,
  output frontend_pkg::decoded_inst_t inst0_o,
  output frontend_pkg::decoded_inst_t inst1_o,
  input  logic [1:0]                  issue_i
);

  logic [1:0]  q_valid;
  logic [1:0]  q_rd_num;
  logic [31:0] q_word0;
  logic [31:0] q_word1;
  logic [31:0] q_pc0;
  logic [31:0] q_pc1;

  fetch_if fif ();

  fetch_unit u_fetch (
    .clk               (clk),
    .rst_n             (rst_n),
    .redirect_i        (redirect_i),
    .redirect_target_i (redirect_target_i),
    .imem_data_i       (imem_data_i),
    .wait_i            (wait_i),
    .int_i             (int_i),
    .imem_req_o        (imem_req_o),
    .imem_addr_o       (imem_addr_o),
    .idle_o            (idle_o),
    .fif               (fif.src)
  );

  // redirect flushes queue and issue slots together
  inst_queue u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (redirect_i),
    .rd_num_i   (q_rd_num),
    .rd_valid_o (q_valid),
    .rd_word0_o (q_word0),
    .rd_word1_o (q_word1),
    .rd_pc0_o   (q_pc0),
    .rd_pc1_o   (q_pc1),
    .fif        (fif.snk)
  );

  issue_buffer u_issue (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i),
    .q_valid_i    (q_valid),
    .q_word0_i    (q_word0),
    .q_word1_i    (q_word1),
    .q_pc0_i      (q_pc0),
    .q_pc1_i      (q_pc1),
    .issue_i      (issue_i),
    .rd_num_o     (q_rd_num),
    .inst_valid_o (inst_valid_o),
    .inst0_o      (inst0_o),
    .inst1_o      (inst1_o)
  );

endmodule

/* testbench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// random program below 0x800, directed words at 0x800..0x83f
localparam int RAND_WORDS = 512;

logic [31:0] rand_mem [RAND_WORDS];

// one encoding of a random class, invalid ones use major 0x3f
function automatic logic [31:0] random_encoding();
  logic [31:0] r;
  int pick;
  r = $random(seed);
  pick = $unsigned($random(seed)) % 10;
  case (pick)
    0: begin
      case (r[31:30])
        2'd0:    return {OP17_ADD_W, r[14:0]};
        2'd1:    return {OP17_SUB_W, r[14:0]};
        2'd2:    return {OP17_AND, r[14:0]};
        default: return {OP17_OR, r[14:0]};
      endcase
    end
    1: return {OP10_ADDI_W, r[21:0]};
    2: return {OP10_LD_W, r[21:0]};
    3: return {OP10_ST_W, r[21:0]};
    4: return {r[31] ? OP6_BNE : OP6_BEQ, r[25:0]};
    5: return {OP6_BL, r[25:0]};
    6: return {OP6_JIRL, r[25:0]};
    7: return {OP7_LU12I_W, r[24:0]};
    8: return {OP17_IDLE, r[14:0]};
    default: return {6'h3f, r[25:0]};
  endcase
endfunction

task automatic fill_memory();
  int i;
  for (i = 0; i < RAND_WORDS; i++) begin
    rand_mem[i] = random_encoding();
  end
endtask

// eight register cases, then eight unsupported encodings
function automatic logic [31:0] directed_word(input logic [3:0] idx);
  case (idx)
    4'd0:    return {OP17_ADD_W, 5'd2, 5'd1, 5'd3};
    4'd1:    return {OP17_SUB_W, 5'd31, 5'd30, 5'd29};
    4'd2:    return {OP10_ST_W, 12'h010, 5'd8, 5'd7};
    4'd3:    return {OP6_BL, 26'h0000040};
    4'd4:    return {OP6_JIRL, 16'h0004, 5'd5, 5'd0};
    4'd5:    return {OP6_JIRL, 16'h0000, 5'd0, 5'd6};
    4'd6:    return {OP6_JIRL, 16'h0008, 5'd18, 5'd9};
    4'd7:    return {OP17_AND, 5'd14, 5'd13, 5'd12};
    4'd8:    return 32'h0000_0000;
    4'd9:    return 32'hffff_ffff;
    4'd10:   return {6'h3f, 26'h1555555};
    4'd11:   return {17'h00021, 15'h1234};
    4'd12:   return {10'h0a4, 22'h03abcd};
    4'd13:   return {6'h14, 26'h2aaaaaa};
    4'd14:   return {17'h00c92, 15'h0000};
    default: return {6'h18, 26'h0000000};
  endcase
endfunction

function automatic logic [31:0] mem_word(input logic [31:0] pc);
  if (pc < 32'h800) begin
    return rand_mem[pc[10:2]];
  end else if (pc < 32'h840) begin
    return directed_word(pc[5:2]);
  end
  // everything above decodes as invalid
  return {6'h3f, pc[27:2]};
endfunction

// expected decode of the word stored at pc
function automatic decoded_inst_t expected_decode(input logic [31:0] pc);
  decoded_inst_t d;
  logic [31:0] w;
  logic [4:0]  rd;
  logic [4:0]  rj;
  logic [4:0]  rk;
  w  = mem_word(pc);
  rd = w[4:0];
  rj = w[9:5];
  rk = w[14:10];
  d  = '0;
  d.pc   = pc;
  d.word = w;
  d.cls  = CLS_INVALID;
  if (w[31:15] == OP17_ADD_W || w[31:15] == OP17_SUB_W ||
      w[31:15] == OP17_AND || w[31:15] == OP17_OR) begin
    d.cls  = CLS_ALU3R;
    d.src0 = rk;
    d.src1 = rj;
    d.dst  = rd;
  end else if (w[31:15] == OP17_IDLE) begin
    d.cls = CLS_IDLE;
  end else if (w[31:22] == OP10_ADDI_W || w[31:22] == OP10_LD_W) begin
    d.cls  = (w[31:22] == OP10_LD_W) ? CLS_LOAD : CLS_ALUI12;
    d.src1 = rj;
    d.dst  = rd;
  end else if (w[31:22] == OP10_ST_W) begin
    d.cls  = CLS_STORE;
    d.src0 = rd;
    d.src1 = rj;
  end else if (w[31:25] == OP7_LU12I_W) begin
    d.cls = CLS_LU12I;
    d.dst = rd;
  end else if (w[31:26] == OP6_BEQ || w[31:26] == OP6_BNE) begin
    d.cls  = CLS_BRANCH;
    d.src0 = rd;
    d.src1 = rj;
  end else if (w[31:26] == OP6_BL) begin
    d.cls = CLS_BL;
    d.dst = 5'd1;
  end else if (w[31:26] == OP6_JIRL) begin
    d.cls  = CLS_JIRL;
    d.src1 = rj;
    d.dst  = rd | rj;
  end
  if (d.cls != CLS_INVALID) begin
    d.dec_valid = 1'b1;
    d.imm26     = w[25:0];
  end
  return d;
endfunction

`endif

/* testbench/tb_frontend.sv */
`timescale 1ns/100ps

module tb_frontend;

  import frontend_pkg::*;

  // about four times the expected length of all tests
  localparam int CYCLE_LIMIT = 4000;
  localparam logic [1:0] MODE_OFF    = 2'd0;
  localparam logic [1:0] MODE_ALL    = 2'd1;
  localparam logic [1:0] MODE_RANDOM = 2'd2;

  integer seed = 3;

  logic          clk = 1'b0;
  logic          rst_n = 1'b0;
  logic          redirect = 1'b0;
  logic [31:0]   redirect_target = '0;
  logic [63:0]   imem_data = '0;
  logic          wait_in = 1'b0;
  logic          int_in = 1'b0;
  logic [1:0]    ack_mask = 2'b00;
  logic [1:0]    ack_mode = MODE_OFF;
  logic [1:0]    issue;
  logic          imem_req;
  logic [31:0]   imem_addr;
  logic          idle;
  logic [1:0]    inst_valid;
  decoded_inst_t inst0;
  decoded_inst_t inst1;

  logic [31:0] exp_pc = '0;
  logic [31:0] first_pc = '0;
  logic [31:0] last_req_addr = '0;
  logic        want_first = 1'b0;
  logic        odd_first = 1'b0;
  int words = 0;
  int issued = 0;
  int invalid_cnt = 0;
  int cmp_errors = 0;
  int mon_errors = 0;
  int test_errors = 0;
  int err_mark = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;

  `include "tb_ref_model.svh"

  core_frontend dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .redirect_i        (redirect),
    .redirect_target_i (redirect_target),
    .imem_req_o        (imem_req),
    .imem_addr_o       (imem_addr),
    .imem_data_i       (imem_data),
    .wait_i            (wait_in),
    .int_i             (int_in),
    .idle_o            (idle),
    .inst_valid_o      (inst_valid),
    .inst0_o           (inst0),
    .inst1_o           (inst1),
    .issue_i           (issue)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  // backend acks held slots only and slot 1 only together with slot 0
  assign issue = {ack_mask[1] & ack_mask[0] & inst_valid[1] & inst_valid[0],
                  ack_mask[0] & inst_valid[0]};

  always @(posedge clk) begin
    case (ack_mode)
      MODE_ALL:    ack_mask <= 2'b11;
      MODE_RANDOM: ack_mask <= $random(seed);
      default:     ack_mask <= 2'b00;
    endcase
  end

  // memory answers one cycle after the request
  always @(posedge clk) begin
    if (imem_req) begin
      imem_data <= {mem_word(imem_addr + 32'd4), mem_word(imem_addr)};
    end
  end

  task automatic report_mismatch(input int slot, input decoded_inst_t got,
                                 input decoded_inst_t exp);
    $display("error at %0t: slot %0d got pc %h cls %0d src0 %0d src1 %0d dst %0d imm %h, %s",
             $time, slot, got.pc, got.cls, got.src0, got.src1, got.dst, got.imm26,
             $sformatf("expected pc %h cls %0d src0 %0d src1 %0d dst %0d imm %h",
                       exp.pc, exp.cls, exp.src0, exp.src1, exp.dst, exp.imm26));
  endtask

  always @(posedge clk) begin : compare
    decoded_inst_t exp0;
    decoded_inst_t exp1;
    int bad;
    bad = 0;
    if (!rst_n) begin
      exp_pc <= '0;
    end else if (redirect) begin
      exp_pc     <= redirect_target;
      want_first <= 1'b1;
    end else if (issue[0]) begin
      exp0 = expected_decode(exp_pc);
      if (inst0 !== exp0) begin
        report_mismatch(0, inst0, exp0);
        bad++;
      end
      if (issue[1]) begin
        exp1 = expected_decode(exp_pc + 32'd4);
        if (inst1 !== exp1) begin
          report_mismatch(1, inst1, exp1);
          bad++;
        end
      end
      if (want_first) begin
        first_pc   <= inst0.pc;
        want_first <= 1'b0;
      end
      exp_pc      <= exp_pc + (issue[1] ? 32'd8 : 32'd4);
      issued      <= issued + (issue[1] ? 2 : 1);
      invalid_cnt <= invalid_cnt + int'(inst0.cls == CLS_INVALID) +
                     int'(issue[1] && inst1.cls == CLS_INVALID);
      cmp_errors  <= cmp_errors + bad;
    end
  end

  // requested words not yet issued are bounded by queue plus issue slots
  always @(posedge clk) begin : occupancy
    int delta;
    delta = 0;
    if (!rst_n || redirect) begin
      words     <= 0;
      odd_first <= redirect && redirect_target[2];
    end else begin
      if (imem_req) begin
        delta = odd_first ? 1 : 2;
        odd_first     <= 1'b0;
        last_req_addr <= imem_addr;
      end
      delta = delta - int'(issue[0]) - int'(issue[1]);
      if (words + delta > QUEUE_DEPTH + 2) begin
        $display("error at %0t: %0d words outstanding, more than the frontend holds",
                 $time, words + delta);
        mon_errors <= mon_errors + 1;
      end
      words <= words + delta;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic wait_issued(input int n);
    int target;
    target = issued + n;
    while (issued < target) begin
      @(posedge clk);
    end
  endtask

  // backend stops acking for the redirect cycle
  task automatic redirect_to(input logic [31:0] target);
    ack_mode <= MODE_OFF;
    @(posedge clk);
    redirect        <= 1'b1;
    redirect_target <= target;
    @(posedge clk);
    redirect <= 1'b0;
    ack_mode <= MODE_ALL;
  endtask

  task automatic finish_test(input string name);
    int total;
    @(posedge clk);
    total = cmp_errors + mon_errors + test_errors;
    tests_run++;
    if (total == err_mark) begin
      $display("test %s: ok, %0d instructions issued so far", name, issued);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, total - err_mark);
    end
    err_mark = total;
  endtask

  initial begin : stimulus
    int total;
    int n;
    int inv_mark;
    logic [31:0] saved_addr;
    fill_memory();
    repeat (10) @(posedge clk);
    // outputs quiet and pc at zero while held in reset
    if (imem_req !== 1'b0 || inst_valid !== 2'b00 || idle !== 1'b0 ||
        imem_addr !== 32'h0000_0000) begin
      $display("error at %0t: in reset req %b valid %b idle %b addr %h, expected 0 0 0 0",
               $time, imem_req, inst_valid, idle, imem_addr);
      test_errors++;
    end
    rst_n    <= 1'b1;
    ack_mode <= MODE_ALL;

    wait_issued(100);
    finish_test("straight-line fetch");

    // random acks and then a long stall to fill the queue
    ack_mode <= MODE_RANDOM;
    wait_issued(60);
    ack_mode <= MODE_OFF;
    repeat (40) @(posedge clk);
    if (imem_req !== 1'b0) begin
      $display("error at %0t: request made with the queue full", $time);
      test_errors++;
    end
    ack_mode <= MODE_RANDOM;
    wait_issued(90);
    finish_test("random back-pressure");

    redirect_to(32'h0000_0104);
    wait_issued(40);
    if (first_pc !== 32'h0000_0104) begin
      $display("error at %0t: first pc after redirect %h, expected 00000104", $time, first_pc);
      test_errors++;
    end
    finish_test("redirect to odd word");

    redirect_to(32'h0000_0800);
    wait_issued(8);
    finish_test("register extraction");

    redirect_to(32'h0000_0400);
    wait_issued(20);
    @(posedge clk);
    wait_in <= 1'b1;
    @(posedge clk);
    wait_in <= 1'b0;
    @(posedge clk);
    saved_addr = last_req_addr;
    if (idle !== 1'b1) begin
      $display("error at %0t: idle_o is %b after wait, expected 1", $time, idle);
      test_errors++;
    end
    repeat (20) begin
      if (imem_req !== 1'b0) begin
        $display("error at %0t: request made while idle", $time);
        test_errors++;
      end
      @(posedge clk);
    end
    int_in <= 1'b1;
    @(posedge clk);
    int_in <= 1'b0;
    n = 0;
    while (imem_req !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (imem_req !== 1'b1) begin
      $display("idle-wait: fetch did not resume after the interrupt");
      test_errors++;
    end else if (imem_addr !== saved_addr + 32'd8) begin
      $display("error at %0t: resumed at %h, expected %h", $time, imem_addr,
               saved_addr + 32'd8);
      test_errors++;
    end
    if (idle !== 1'b0) begin
      $display("error at %0t: idle_o still high after interrupt", $time);
      test_errors++;
    end
    wait_issued(20);
    finish_test("idle-wait");

    // everything from 0x820 on is unsupported
    inv_mark = invalid_cnt;
    redirect_to(32'h0000_0820);
    wait_issued(24);
    @(posedge clk);
    if (invalid_cnt - inv_mark < 24) begin
      $display("error at %0t: %0d invalid words issued, expected at least 24", $time,
               invalid_cnt - inv_mark);
      test_errors++;
    end
    finish_test("invalid words");

    total = cmp_errors + mon_errors + test_errors;
    $display("tests run %0d, failed %0d, instructions checked %0d, errors %0d",
             tests_run, tests_failed, issued, total);
    if (total == 0 && tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+testbench
common/frontend_pkg.sv
common/fetch_if.sv
fetch/fetch_unit.sv
logic/inst_queue.sv
decode/inst_decoder.sv
decode/issue_buffer.sv
logic/core_frontend.sv
testbench/tb_frontend.sv
